/* source/fpu_pkg.sv */
/*
 * fpu package
 * shared types, encodings and constants for the binary32 execution unit
 */
package fpu_pkg;

   // ----------------------------------------
   // binary32 field layout
   // ----------------------------------------
   localparam int EXP_W    = 8;    // biased exponent bits
   localparam int MAN_W    = 23;   // stored fraction bits
   localparam int EXP_BIAS = 127;

   typedef logic [31:0] fp32_t;      // raw binary32 word
   typedef logic [4:0]  reg_addr_t;  // destination register index

   // flags in riscv fflags order
   typedef logic [4:0] status_t;
   localparam int ST_NV = 4;   // invalid
   localparam int ST_DZ = 3;   // divide by zero
   localparam int ST_OF = 2;   // overflow
   localparam int ST_UF = 1;   // underflow
   localparam int ST_NX = 0;   // inexact

   // ----------------------------------------
   // internal number representation
   // ----------------------------------------
   typedef logic signed [9:0] exp_t;      // unbiased, room for over/underflow
   typedef logic [MAN_W:0]    sig_t;      // hidden bit + fraction
   typedef logic [MAN_W+3:0]  ext_sig_t;  // sig + guard, round, sticky

   // one-hot operand / result class
   typedef logic [3:0] fp_class_t;
   localparam fp_class_t CLS_ZERO = 4'b0001;
   localparam fp_class_t CLS_INF  = 4'b0010;
   localparam fp_class_t CLS_NAN  = 4'b0100;
   localparam fp_class_t CLS_NORM = 4'b1000;

   localparam fp32_t CANON_NAN = 32'h7fc0_0000;  // riscv canonical qnan

   // ----------------------------------------
   // issue side and internal operations
   // ----------------------------------------
   typedef enum logic [2:0] {
      FADD,
      FSUB,
      FMUL,
      FDIV,
      FMADD,
      FMIN_MAX,
      FCVT
   } instr_type_t;

   typedef enum logic {
      OP_ADD,   // add, subtract when op_mod set
      OP_MUL
   } fpu_op_e;

endpackage

/* source/fpu_unpack.sv */
/*
 * binary32 unpacker
 * splits a word into sign, unbiased exponent and significand, and classifies it
 */
`timescale 1ns/100ps

module fpu_unpack (
   input  fpu_pkg::fp32_t      word_i,
   output logic                sign_o,
   output fpu_pkg::exp_t       exp_o,
   output fpu_pkg::sig_t       sig_o,
   output fpu_pkg::fp_class_t  class_o
);

logic [fpu_pkg::EXP_W-1:0] biased;
logic [fpu_pkg::MAN_W-1:0] man;

assign sign_o = word_i[31];
assign biased = word_i[fpu_pkg::MAN_W +: fpu_pkg::EXP_W];
assign man    = word_i[fpu_pkg::MAN_W-1:0];
assign exp_o  = $signed({2'b00, biased}) - fpu_pkg::exp_t'(fpu_pkg::EXP_BIAS);

always_comb begin
   sig_o = {1'b1, man};                // restore hidden bit
   if (biased == '0) begin
      class_o = fpu_pkg::CLS_ZERO;     // zero, denormals flushed
      sig_o   = '0;
   end else if (biased == '1) begin
      // all ones exponent
      class_o = (man == '0) ? fpu_pkg::CLS_INF : fpu_pkg::CLS_NAN;
   end else begin
      class_o = fpu_pkg::CLS_NORM;
   end
end

endmodule

/* source/fpu_addsub.sv */
/*
 * binary32 adder / subtractor
 * swap, align with sticky, add or subtract magnitudes, normalise by leading zeros
 */
`timescale 1ns/100ps

module fpu_addsub (
   input  logic                sub_i,
   input  logic                a_sign_i,
   input  fpu_pkg::exp_t       a_exp_i,
   input  fpu_pkg::sig_t       a_sig_i,
   input  fpu_pkg::fp_class_t  a_class_i,
   input  logic                b_sign_i,
   input  fpu_pkg::exp_t       b_exp_i,
   input  fpu_pkg::sig_t       b_sig_i,
   input  fpu_pkg::fp_class_t  b_class_i,
   output logic                sign_o,
   output fpu_pkg::exp_t       exp_o,
   output fpu_pkg::ext_sig_t   sig_o,
   output fpu_pkg::fp_class_t  class_o,
   output logic                invalid_o
);

// leading zero count over the 27 bit sum
function automatic logic [4:0] lzc(input fpu_pkg::ext_sig_t v);
   logic [4:0] n;
   logic       found;
   n     = '0;
   found = 1'b0;
   for (int i = $bits(fpu_pkg::ext_sig_t) - 1; i >= 0; i--) begin
      if (!found) begin
         if (v[i]) found = 1'b1;
         else      n = n + 5'd1;
      end
   end
   return n;
endfunction

logic b_sign_eff, a_big, eff_sub, sticky;
logic big_sign;
fpu_pkg::exp_t big_exp, small_exp, diff;
fpu_pkg::sig_t big_sig, small_sig;
fpu_pkg::ext_sig_t small_ext, small_shift, lost_mask;
logic [27:0] sum;                     // one carry bit on top
logic [4:0] lz;

assign b_sign_eff = b_sign_i ^ sub_i;
assign a_big = (a_exp_i > b_exp_i) || ((a_exp_i == b_exp_i) && (a_sig_i >= b_sig_i));

// ---- swap, larger magnitude first
assign big_sign  = a_big ? a_sign_i : b_sign_eff;
assign big_exp   = a_big ? a_exp_i  : b_exp_i;
assign small_exp = a_big ? b_exp_i  : a_exp_i;
assign big_sig   = a_big ? a_sig_i  : b_sig_i;
assign small_sig = a_big ? b_sig_i  : a_sig_i;
assign eff_sub   = a_sign_i ^ b_sign_eff;
assign diff      = big_exp - small_exp;     // never negative

// ---- alignment
always_comb begin
   small_ext = {small_sig, 3'b000};
   lost_mask = ~({$bits(fpu_pkg::ext_sig_t){1'b1}} << diff[4:0]);
   if (diff > 10'sd26) begin
      small_shift = '0;                     // shifted out completely
      sticky      = |small_sig;
   end else begin
      small_shift = small_ext >> diff[4:0];
      sticky      = |(small_ext & lost_mask);
   end
   small_shift[0] = small_shift[0] | sticky;
end

assign sum = eff_sub ? ({1'b0, big_sig, 3'b000} - {1'b0, small_shift})
                     : ({1'b0, big_sig, 3'b000} + {1'b0, small_shift});
assign lz  = lzc(sum[26:0]);

// ---- normalise
always_comb begin
   if (sum[27]) begin                       // carry out, one place right
      sig_o = {sum[27:2], sum[1] | sum[0]};
      exp_o = big_exp + 10'sd1;
   end else begin
      sig_o = sum[26:0] << lz;
      exp_o = big_exp - $signed({5'b00000, lz});
   end
end

// ---- special values
always_comb begin
   invalid_o = 1'b0;
   sign_o    = big_sign;
   class_o   = fpu_pkg::CLS_NORM;
   if ((a_class_i == fpu_pkg::CLS_NAN) || (b_class_i == fpu_pkg::CLS_NAN)) begin
      class_o = fpu_pkg::CLS_NAN;
   end else if ((a_class_i == fpu_pkg::CLS_INF) && (b_class_i == fpu_pkg::CLS_INF)
                && eff_sub) begin
      class_o   = fpu_pkg::CLS_NAN;         // inf - inf
      invalid_o = 1'b1;
   end else if (a_class_i == fpu_pkg::CLS_INF) begin
      class_o = fpu_pkg::CLS_INF;
      sign_o  = a_sign_i;
   end else if (b_class_i == fpu_pkg::CLS_INF) begin
      class_o = fpu_pkg::CLS_INF;
      sign_o  = b_sign_eff;
   end else if (sum == '0) begin
      class_o = fpu_pkg::CLS_ZERO;
      sign_o  = a_sign_i & b_sign_eff;      // -0 only for -0 + -0
   end
end

endmodule

/* source/fpu_mul.sv */
/*
 * binary32 multiplier
 * 24x24 significand product, exponent sum, one-place normalise
 */
`timescale 1ns/100ps

module fpu_mul (
   input  logic                a_sign_i,
   input  fpu_pkg::exp_t       a_exp_i,
   input  fpu_pkg::sig_t       a_sig_i,
   input  fpu_pkg::fp_class_t  a_class_i,
   input  logic                b_sign_i,
   input  fpu_pkg::exp_t       b_exp_i,
   input  fpu_pkg::sig_t       b_sig_i,
   input  fpu_pkg::fp_class_t  b_class_i,
   output logic                sign_o,
   output fpu_pkg::exp_t       exp_o,
   output fpu_pkg::ext_sig_t   sig_o,
   output fpu_pkg::fp_class_t  class_o,
   output logic                invalid_o
);

logic [47:0] prod;            // 1.x * 1.x lands in [1, 4)
logic        any_zero, any_inf;

assign prod     = a_sig_i * b_sig_i;
assign sign_o   = a_sign_i ^ b_sign_i;
assign any_zero = (a_class_i == fpu_pkg::CLS_ZERO) || (b_class_i == fpu_pkg::CLS_ZERO);
assign any_inf  = (a_class_i == fpu_pkg::CLS_INF)  || (b_class_i == fpu_pkg::CLS_INF);

always_comb begin
   if (prod[47]) begin
      // product >= 2, drop one more bit
      sig_o = {prod[47:24], prod[23], prod[22], |prod[21:0]};
      exp_o = a_exp_i + b_exp_i + 10'sd1;
   end else begin
      sig_o = {prod[46:23], prod[22], prod[21], |prod[20:0]};
      exp_o = a_exp_i + b_exp_i;
   end
end

// class of the product
always_comb begin
   invalid_o = 1'b0;
   if ((a_class_i == fpu_pkg::CLS_NAN) || (b_class_i == fpu_pkg::CLS_NAN)) begin
      class_o = fpu_pkg::CLS_NAN;
   end else if (any_zero && any_inf) begin
      class_o   = fpu_pkg::CLS_NAN;   // 0 * inf
      invalid_o = 1'b1;
   end else if (any_inf) begin
      class_o = fpu_pkg::CLS_INF;
   end else if (any_zero) begin
      class_o = fpu_pkg::CLS_ZERO;
   end else begin
      class_o = fpu_pkg::CLS_NORM;
   end
end

endmodule

/* source/fpu_round.sv */
/*
 * binary32 rounder and packer
 * round to nearest even, range checks, special values, riscv flags
 */
`timescale 1ns/100ps

module fpu_round (
   input  logic                sign_i,
   input  fpu_pkg::exp_t       exp_i,
   input  fpu_pkg::ext_sig_t   sig_i,      // hidden bit at the top
   input  fpu_pkg::fp_class_t  class_i,
   input  logic                invalid_i,
   output fpu_pkg::fp32_t      result_o,
   output fpu_pkg::status_t    status_o
);

logic lsb, guard, rest, round_up, inexact;
logic [24:0] rounded;                      // carry + 24 bit significand
logic [fpu_pkg::MAN_W-1:0] man;
fpu_pkg::exp_t biased;

assign lsb      = sig_i[3];
assign guard    = sig_i[2];
assign rest     = sig_i[1] | sig_i[0];     // round and sticky
assign round_up = guard & (rest | lsb);    // ties go to even
assign inexact  = guard | rest;
assign rounded  = {1'b0, sig_i[26:3]} + 25'(round_up);

// carry out of rounding, 1.111.. became 10.000..
assign man    = rounded[24] ? rounded[23:1] : rounded[22:0];
assign biased = exp_i + fpu_pkg::exp_t'(rounded[24]) + fpu_pkg::exp_t'(fpu_pkg::EXP_BIAS);

always_comb begin
   result_o = '0;
   status_o = '0;
   status_o[fpu_pkg::ST_DZ] = 1'b0;        // no divide in this unit
   if (invalid_i) begin
      result_o = fpu_pkg::CANON_NAN;
      status_o[fpu_pkg::ST_NV] = 1'b1;
   end else if (class_i == fpu_pkg::CLS_NAN) begin
      result_o = fpu_pkg::CANON_NAN;       // quiet propagation
   end else if (class_i == fpu_pkg::CLS_INF) begin
      result_o = {sign_i, 8'hff, 23'd0};
   end else if (class_i == fpu_pkg::CLS_ZERO) begin
      result_o = {sign_i, 31'd0};
   end else if (biased >= 10'sd255) begin
      result_o = {sign_i, 8'hff, 23'd0};   // overflow to inf
      status_o[fpu_pkg::ST_OF] = 1'b1;
      status_o[fpu_pkg::ST_NX] = 1'b1;
   end else if (biased <= 10'sd0) begin
      result_o = {sign_i, 31'd0};          // flush tiny to signed zero
      status_o[fpu_pkg::ST_UF] = 1'b1;
      status_o[fpu_pkg::ST_NX] = 1'b1;
   end else begin
      result_o = {sign_i, biased[7:0], man};
      status_o[fpu_pkg::ST_NX] = inexact;
   end
end

endmodule

/* source/fpu_pipe.sv */
/*
 * fpu pipeline
 * unpack and add/mul in stage 1, round in stage 2, output regs in stage 3
 * valid, tag and illegal travel with every item, kill flushes all stages
 */
`timescale 1ns/100ps

module fpu_pipe #(
   parameter int TAG_W = 5
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                kill_i,
   input  logic                in_valid_i,
   input  fpu_pkg::fpu_op_e    op_i,
   input  logic                op_mod_i,    // subtract for OP_ADD
   input  logic                illegal_i,
   input  logic [TAG_W-1:0]    tag_i,
   input  fpu_pkg::fp32_t      op_a_i,
   input  fpu_pkg::fp32_t      op_b_i,
   output logic                out_valid_o,
   output logic [TAG_W-1:0]    tag_o,
   output fpu_pkg::fp32_t      result_o,
   output fpu_pkg::status_t    status_o,
   output logic                illegal_o
);

// unpacked operands
logic a_sign, b_sign;
fpu_pkg::exp_t a_exp, b_exp;
fpu_pkg::sig_t a_sig, b_sig;
fpu_pkg::fp_class_t a_class, b_class;

// adder and multiplier results, both computed every cycle
logic add_sign, mul_sign, add_inv, mul_inv;
fpu_pkg::exp_t add_exp, mul_exp;
fpu_pkg::ext_sig_t add_sig, mul_sig;
fpu_pkg::fp_class_t add_class, mul_class;

// stage registers
logic s1_valid, s2_valid, s3_valid;
logic s1_illegal, s2_illegal, s3_illegal;
logic [TAG_W-1:0] s1_tag, s2_tag, s3_tag;
logic s1_sign, s1_inv;
fpu_pkg::exp_t s1_exp;
fpu_pkg::ext_sig_t s1_sig;
fpu_pkg::fp_class_t s1_class;
fpu_pkg::fp32_t rnd_word, s2_result, s3_result;
fpu_pkg::status_t rnd_status, s2_status, s3_status;

fpu_unpack unpack_a_inst (.word_i(op_a_i), .sign_o(a_sign), .exp_o(a_exp),
                          .sig_o(a_sig), .class_o(a_class));
fpu_unpack unpack_b_inst (.word_i(op_b_i), .sign_o(b_sign), .exp_o(b_exp),
                          .sig_o(b_sig), .class_o(b_class));

fpu_addsub addsub_inst (
   .sub_i(op_mod_i),
   .a_sign_i(a_sign), .a_exp_i(a_exp), .a_sig_i(a_sig), .a_class_i(a_class),
   .b_sign_i(b_sign), .b_exp_i(b_exp), .b_sig_i(b_sig), .b_class_i(b_class),
   .sign_o(add_sign), .exp_o(add_exp), .sig_o(add_sig), .class_o(add_class),
   .invalid_o(add_inv));

fpu_mul mul_inst (
   .a_sign_i(a_sign), .a_exp_i(a_exp), .a_sig_i(a_sig), .a_class_i(a_class),
   .b_sign_i(b_sign), .b_exp_i(b_exp), .b_sig_i(b_sig), .b_class_i(b_class),
   .sign_o(mul_sign), .exp_o(mul_exp), .sig_o(mul_sig), .class_o(mul_class),
   .invalid_o(mul_inv));

fpu_round round_inst (
   .sign_i(s1_sign), .exp_i(s1_exp), .sig_i(s1_sig), .class_i(s1_class),
   .invalid_i(s1_inv), .result_o(rnd_word), .status_o(rnd_status));

// ----------------------------------------
// control: valid and illegal bits
// ----------------------------------------
always_ff @(posedge clk_i) begin
   if (rst_i || kill_i) begin   // flush drops the incoming item too
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      s3_valid   <= 1'b0;
      s3_illegal <= 1'b0;
   end else begin
      s1_valid   <= in_valid_i;
      s2_valid   <= s1_valid;
      s3_valid   <= s2_valid;
      s3_illegal <= s2_valid & s2_illegal;   // only flagged with a result
   end
end

// ----------------------------------------
// payload, no reset
// ----------------------------------------
always_ff @(posedge clk_i) begin
   s1_tag     <= tag_i;
   s1_illegal <= illegal_i;
   s1_sign    <= (op_i == fpu_pkg::OP_MUL) ? mul_sign  : add_sign;
   s1_exp     <= (op_i == fpu_pkg::OP_MUL) ? mul_exp   : add_exp;
   s1_sig     <= (op_i == fpu_pkg::OP_MUL) ? mul_sig   : add_sig;
   s1_class   <= (op_i == fpu_pkg::OP_MUL) ? mul_class : add_class;
   s1_inv     <= (op_i == fpu_pkg::OP_MUL) ? mul_inv   : add_inv;
   s2_tag     <= s1_tag;
   s2_illegal <= s1_illegal;
   s2_result  <= rnd_word;
   s2_status  <= rnd_status;
   s3_tag     <= s2_tag;
   s3_result  <= s2_illegal ? '0 : s2_result;   // illegal answers zero
   s3_status  <= s2_illegal ? '0 : s2_status;
end

assign out_valid_o = s3_valid;
assign tag_o       = s3_tag;
assign result_o    = s3_result;
assign status_o    = s3_status;
assign illegal_o   = s3_illegal;

endmodule

/* source/fpu_exe_wrapper.sv */
/*
 * fpu execution wrapper
 * decodes an issued fp instruction into operation, modifier and legality
 * and drives the three-stage binary32 pipeline
 */
`timescale 1ns/100ps

module fpu_exe_wrapper #(
   parameter int TAG_W = 5
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  kill_i,        // flush everything in flight
   // issue side
   input  logic                  valid_i,
   input  fpu_pkg::instr_type_t  instr_type_i,
   input  logic                  fmt_i,         // 1 = binary64
   input  fpu_pkg::reg_addr_t    rd_i,
   input  fpu_pkg::fp32_t        rs1_data_i,
   input  fpu_pkg::fp32_t        rs2_data_i,
   // writeback side
   output logic                  valid_o,
   output fpu_pkg::reg_addr_t    rd_o,
   output fpu_pkg::fp32_t        result_o,
   output fpu_pkg::status_t      status_o,
   output logic                  illegal_o
);

fpu_pkg::fpu_op_e   op;
logic               op_mod;
logic               type_bad;     // type not handled here
logic               illegal;
logic [TAG_W-1:0]   pipe_tag;

// ----------------------------------------
// instruction decode
// ----------------------------------------
always_comb begin
   op       = fpu_pkg::OP_ADD;
   op_mod   = 1'b0;
   type_bad = 1'b0;
   case (instr_type_i)
      fpu_pkg::FADD: begin
         op     = fpu_pkg::OP_ADD;
         op_mod = 1'b0;
      end
      fpu_pkg::FSUB: begin
         op     = fpu_pkg::OP_ADD;   // add with b negated
         op_mod = 1'b1;
      end
      fpu_pkg::FMUL: begin
         op     = fpu_pkg::OP_MUL;
         op_mod = 1'b0;
      end
      default: begin
         // div, fma, min/max, cvt go elsewhere
         type_bad = 1'b1;
      end
   endcase
end

// double precision not built, answered as illegal
assign illegal = type_bad | fmt_i;

// ----------------------------------------
// arithmetic pipeline
// ----------------------------------------
fpu_pipe #(
   .TAG_W       ( TAG_W )
) fpu_pipe_inst (
   .clk_i       ( clk_i ),
   .rst_i       ( rst_i ),
   .kill_i      ( kill_i ),
   .in_valid_i  ( valid_i ),
   .op_i        ( op ),
   .op_mod_i    ( op_mod ),
   .illegal_i   ( illegal ),
   .tag_i       ( TAG_W'(rd_i) ),     // rd rides along as the tag
   .op_a_i      ( rs1_data_i ),
   .op_b_i      ( rs2_data_i ),
   .out_valid_o ( valid_o ),
   .tag_o       ( pipe_tag ),
   .result_o    ( result_o ),
   .status_o    ( status_o ),
   .illegal_o   ( illegal_o )
);

assign rd_o = fpu_pkg::reg_addr_t'(pipe_tag);

endmodule

/* sim/fpu_exe_assert.sv */
/*
 * protocol checker for the fpu execution unit
 * latency, flush and reset rules, bound into the wrapper
 */
`timescale 1ns/100ps

module fpu_exe_assert (
   input logic clk_i,
   input logic rst_i,
   input logic kill_i,
   input logic valid_i,
   input logic valid_o,
   input logic illegal_o
);

int fail_count = 0;   // failed assertion attempts

// ----------------------------------------
// latency
// ----------------------------------------
// accepted item shows on the third edge unless flushed on the way
property p_latency;
   @(posedge clk_i) disable iff (rst_i)
      (valid_i && !kill_i) ##1 !kill_i ##1 !kill_i |=> valid_o;
endproperty

a_latency: assert property (p_latency)
   else begin
      $error("result missing three cycles after an accepted instruction");
      fail_count++;
   end

a_no_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
   valid_o |-> $past(valid_i, 3))   // every result has its instruction
   else begin
      $error("result without an instruction three cycles earlier");
      fail_count++;
   end

// ----------------------------------------
// flush and reset
// ----------------------------------------
a_flush: assert property (@(posedge clk_i) disable iff (rst_i)
   kill_i |=> (!valid_o) [*3])      // next entry needs three more edges
   else begin
      $error("result within three cycles of a flush");
      fail_count++;
   end

a_reset: assert property (@(posedge clk_i)
   rst_i |=> (!valid_o && !illegal_o))
   else begin
      $error("valid_o or illegal_o high after reset");
      fail_count++;
   end

endmodule

bind fpu_exe_wrapper fpu_exe_assert fpu_exe_assert_inst (
   .clk_i     ( clk_i ),
   .rst_i     ( rst_i ),
   .kill_i    ( kill_i ),
   .valid_i   ( valid_i ),
   .valid_o   ( valid_o ),
   .illegal_o ( illegal_o )
);

/* sim/tb_fpu_exe.sv */
/*
 * testbench for the binary32 execution unit
 * random and directed add/sub/mul, illegal, flush and reset runs
 * checked against a reference model in real arithmetic
 */
`timescale 1ns/100ps

module tb_fpu_exe;

localparam int          TIMEOUT = 40;             // cycles allowed per drain
localparam logic [31:0] SEED    = 32'h8985_61cc;

logic                  clk_i = 1'b0;
logic                  rst_i;
logic                  kill_i;
logic                  valid_i;
fpu_pkg::instr_type_t  instr_type_i;
logic                  fmt_i;
fpu_pkg::reg_addr_t    rd_i;
fpu_pkg::fp32_t        rs1_data_i;
fpu_pkg::fp32_t        rs2_data_i;
logic                  valid_o;
fpu_pkg::reg_addr_t    rd_o;
fpu_pkg::fp32_t        result_o;
fpu_pkg::status_t      status_o;
logic                  illegal_o;

logic [42:0] exp_q[$];     // {illegal, rd, flags, word} per issued item
int          errors = 0;
int          tests_ok = 0;
int          tests_bad = 0;

always #2 clk_i = ~clk_i;  // 4 ns period

fpu_exe_wrapper #(
   .TAG_W        ( 5 )
) fpu_exe_wrapper_inst (
   .clk_i        ( clk_i ),
   .rst_i        ( rst_i ),
   .kill_i       ( kill_i ),
   .valid_i      ( valid_i ),
   .instr_type_i ( instr_type_i ),
   .fmt_i        ( fmt_i ),
   .rd_i         ( rd_i ),
   .rs1_data_i   ( rs1_data_i ),
   .rs2_data_i   ( rs2_data_i ),
   .valid_o      ( valid_o ),
   .rd_o         ( rd_o ),
   .result_o     ( result_o ),
   .status_o     ( status_o ),
   .illegal_o    ( illegal_o )
);

// ----------------------------------------
// reference model
// ----------------------------------------
function automatic real to_real(input fpu_pkg::fp32_t w);
   logic [10:0] e;
   if (w[30:23] == 8'd0) return 0.0;          // subnormal reads as zero
   e = {3'b000, w[30:23]} + 11'd896;          // rebias 127 -> 1023
   return $bitstoreal({w[31], e, w[22:0], 29'd0});
endfunction

// double to binary32, nearest even, result assumed normal
function automatic fpu_pkg::fp32_t to_fp32(input real r);
   logic [63:0] d;
   logic [24:0] keep;
   logic [10:0] e;
   d    = $realtobits(r);
   keep = {2'b01, d[51:29]};
   e    = d[62:52];
   if (d[62:0] == 63'd0) return {d[63], 31'd0};
   if (d[28] && ((|d[27:0]) || keep[0])) keep = keep + 25'd1;
   if (keep[24]) begin                        // rounding carried out
      keep = keep >> 1;
      e    = e + 11'd1;
   end
   return {d[63], 8'(e - 11'd896), keep[22:0]};
endfunction

// {flags, word}, nx when the packed word no longer equals the exact value
function automatic logic [36:0] model(input fpu_pkg::instr_type_t t,
                                      input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b);
   real            exact;
   fpu_pkg::fp32_t res;
   case (t)
      fpu_pkg::FSUB: exact = to_real(a) - to_real(b);
      fpu_pkg::FMUL: exact = to_real(a) * to_real(b);
      default:       exact = to_real(a) + to_real(b);
   endcase
   res = to_fp32(exact);
   return {4'b0000, (to_real(res) != exact), res};
endfunction

// ----------------------------------------
// result checker, outputs stable at negedge
// ----------------------------------------
task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] want);
   assert (got === want) else begin
      $display("Fail t=%0t %s: expected %0h, got %0h", $time, name, want, got);
      errors++;
   end
endtask

always @(negedge clk_i) begin : check_results
   logic [42:0] e;
   assert (valid_o || !illegal_o) else begin
      $display("illegal_o was high at %0t without a result", $time);
      errors++;
   end
   if (valid_o) begin
      if (exp_q.size() == 0) begin
         $display("a result came out at %0t with nothing pending", $time);
         errors++;
      end else begin
         e = exp_q.pop_front();
         compare_field("result_o", result_o, e[31:0]);
         compare_field("status_o", 32'(status_o), 32'(e[36:32]));
         compare_field("rd_o", 32'(rd_o), 32'(e[41:37]));
         compare_field("illegal_o", 32'(illegal_o), 32'(e[42]));
      end
   end
end

// ----------------------------------------
// stimulus helpers
// ----------------------------------------
// want is {illegal, flags, word}
task automatic issue(input fpu_pkg::instr_type_t t, input logic fmt, input fpu_pkg::reg_addr_t rd,
                     input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b, input logic [37:0] want);
   @(posedge clk_i);
   #1;
   valid_i      = 1'b1;
   kill_i       = 1'b0;
   instr_type_i = t;
   fmt_i        = fmt;
   rd_i         = rd;
   rs1_data_i   = a;
   rs2_data_i   = b;
   exp_q.push_back({want[37], rd, want[36:0]});
endtask

// normal operands, exponents within 9 of each other
task automatic issue_rand(input fpu_pkg::reg_addr_t rd);
   int                   e;
   fpu_pkg::fp32_t       a;
   fpu_pkg::fp32_t       b;
   fpu_pkg::instr_type_t t;
   e = $urandom_range(145, 110);
   a = {1'($urandom), 8'(e), 23'($urandom)};
   b = {1'($urandom), 8'(e + int'($urandom_range(18, 0)) - 9), 23'($urandom)};
   t = fpu_pkg::instr_type_t'($urandom_range(2, 0));
   issue(t, 1'b0, rd, a, b, {1'b0, model(t, a, b)});
endtask

// stop issuing, wait for every pending result, report the test
task automatic finish_test(input string name, input int err0);
   int cycles;
   cycles = 0;
   @(posedge clk_i);
   #1;
   valid_i = 1'b0;
   kill_i  = 1'b0;
   while (exp_q.size() != 0 && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
   end
   if (exp_q.size() != 0) begin
      $display("timeout in %s: %0d results never came out", name, exp_q.size());
      errors++;
      exp_q.delete();
   end
   if (errors == err0) begin
      tests_ok++;
      $display("test %-8s ok", name);
   end else begin
      tests_bad++;
      $display("test %-8s failed with %0d errors", name, errors - err0);
   end
endtask

// ----------------------------------------
// test sequence
// ----------------------------------------
initial begin
   int          err0;
   void'($urandom(SEED));
   rst_i        = 1'b1;
   kill_i       = 1'b0;
   valid_i      = 1'b0;
   fmt_i        = 1'b0;
   instr_type_i = fpu_pkg::FADD;
   rd_i         = '0;
   rs1_data_i   = '0;
   rs2_data_i   = '0;
   repeat (4) @(posedge clk_i);
   #1;
   rst_i = 1'b0;

   err0 = errors;                              // back to back, three in flight
   for (int i = 0; i < 24; i++) issue_rand(fpu_pkg::reg_addr_t'(i));
   finish_test("random", err0);

   err0 = errors;
   issue(fpu_pkg::FSUB, 1'b0, 5'd1, 32'h7f80_0000, 32'h7f80_0000, {1'b0, 5'b10000, 32'h7fc0_0000});
   issue(fpu_pkg::FMUL, 1'b0, 5'd2, 32'h0000_0000, 32'h7f80_0000, {1'b0, 5'b10000, 32'h7fc0_0000});
   issue(fpu_pkg::FADD, 1'b0, 5'd3, 32'h7fc0_0001, 32'h3f80_0000, {1'b0, 5'b00000, 32'h7fc0_0000});
   issue(fpu_pkg::FSUB, 1'b0, 5'd4, 32'h4049_0fdb, 32'h4049_0fdb, {1'b0, 5'b00000, 32'h0000_0000});
   issue(fpu_pkg::FADD, 1'b0, 5'd5, 32'h0000_0001, 32'h3f80_0000, {1'b0, 5'b00000, 32'h3f80_0000});
   issue(fpu_pkg::FMUL, 1'b0, 5'd6, 32'h0040_0000, 32'h4000_0000, {1'b0, 5'b00000, 32'h0000_0000});
   finish_test("special", err0);

   err0 = errors;                              // 2^100 squared, -2^-70 * 2^-70
   issue(fpu_pkg::FMUL, 1'b0, 5'd7, 32'h7180_0000, 32'h7180_0000, {1'b0, 5'b00101, 32'h7f80_0000});
   issue(fpu_pkg::FMUL, 1'b0, 5'd8, 32'h9c80_0000, 32'h1c80_0000, {1'b0, 5'b00011, 32'h8000_0000});
   finish_test("range", err0);

   err0 = errors;
   issue(fpu_pkg::FADD, 1'b0, 5'd9, 32'h3f80_0000, 32'h4000_0000,
         {1'b0, model(fpu_pkg::FADD, 32'h3f80_0000, 32'h4000_0000)});
   issue(fpu_pkg::FDIV, 1'b0, 5'd10, 32'h3f80_0000, 32'h4000_0000, {1'b1, 37'd0});
   issue(fpu_pkg::FMUL, 1'b0, 5'd11, 32'h4000_0000, 32'h4040_0000,
         {1'b0, model(fpu_pkg::FMUL, 32'h4000_0000, 32'h4040_0000)});
   issue(fpu_pkg::FMADD, 1'b0, 5'd12, 32'h3f80_0000, 32'h3f80_0000, {1'b1, 37'd0});
   issue(fpu_pkg::FADD, 1'b1, 5'd13, 32'h3f80_0000, 32'h3f80_0000, {1'b1, 37'd0});
   finish_test("illegal", err0);

   err0 = errors;                              // two in the pipe, third dropped with the kill
   issue_rand(5'd15);
   issue_rand(5'd16);
   @(posedge clk_i);
   #1;
   instr_type_i = fpu_pkg::FSUB;
   rd_i         = 5'd17;
   kill_i       = 1'b1;
   exp_q.delete();
   for (int i = 18; i < 21; i++) issue_rand(fpu_pkg::reg_addr_t'(i));
   finish_test("flush", err0);

   err0 = errors;
   issue_rand(5'd21);
   issue_rand(5'd22);
   @(posedge clk_i);
   #1;
   valid_i = 1'b0;
   rst_i   = 1'b1;
   exp_q.delete();                             // nothing pending survives reset
   repeat (4) @(posedge clk_i);
   #1;
   rst_i = 1'b0;
   repeat (6) @(posedge clk_i);                // checker flags any stray result
   issue_rand(5'd23);
   issue_rand(5'd24);
   finish_test("reset", err0);

   errors += fpu_exe_wrapper_inst.fpu_exe_assert_inst.fail_count;   // protocol assertions
   $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
   if (tests_bad == 0 && errors == 0) begin
      $display("TEST PASSED");
   end else begin
      $display("TEST FAILED");
   end
   $finish;
end

endmodule

/* filelist.f */
source/fpu_pkg.sv
source/fpu_unpack.sv
source/fpu_addsub.sv
source/fpu_mul.sv
source/fpu_round.sv
source/fpu_pipe.sv
source/fpu_exe_wrapper.sv
sim/fpu_exe_assert.sv
sim/tb_fpu_exe.sv

/* Bender.yml */
package:
  name: fpu_exe

sources:
  - source/fpu_pkg.sv
  - source/fpu_unpack.sv
  - source/fpu_addsub.sv
  - source/fpu_mul.sv
  - source/fpu_round.sv
  - source/fpu_pipe.sv
  - source/fpu_exe_wrapper.sv
  - target: test
    files:
      - sim/fpu_exe_assert.sv
      - sim/tb_fpu_exe.sv
